/* pe_cluster.f */
hw/cluster_cfg_pkg.sv
hw/pe_word_pkg.sv
hw/stream_switch.sv
hw/pe_alu.sv
hw/pe_latency_timer.sv
hw/pe_sequencer.sv
hw/pe_wrapper.sv
hw/pe_cluster_top.sv
test/pe_cluster_properties.sv
test/tb_pe_cluster.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pe_cluster -f pe_cluster.f -o tb_pe_cluster
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_pe_cluster > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* test/tb_pe_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pe_cluster;

    localparam int NUM_PE  = 4;
    localparam int DESTW   = 3;
    localparam int TIMEOUT = 2000;

    logic                                CLK;
    logic                                rst_n;
    logic                                s_tvalid;
    logic [cluster_cfg_pkg::DATAW-1:0]   s_tdata;
    logic [DESTW-1:0]                    s_tdest;
    logic                                s_tready;
    logic [NUM_PE-1:0][DESTW-1:0]        pe_route;
    logic                                m_tvalid;
    logic [cluster_cfg_pkg::DATAW-1:0]   m_tdata;
    logic                                m_tready;

    // route of each element, NUM_PE means host
    int          route_tab [NUM_PE];
    int          err_cnt;
    int          check_cnt;
    // cycles the host input spent waiting for s_tready
    int          stall_cnt;
    integer      seed;
    // words to send and their entry ports
    logic [31:0] tx_word_q [$];
    int          tx_dest_q [$];
    // results still owed by the DUT
    logic [31:0] exp_q [$];

    pe_cluster_top #(
        .NUM_PE (NUM_PE),
        .DESTW  (DESTW)
    ) i_dut (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .s_tvalid (s_tvalid),
        .s_tdata  (s_tdata),
        .s_tdest  (s_tdest),
        .s_tready (s_tready),
        .pe_route (pe_route),
        .m_tvalid (m_tvalid),
        .m_tdata  (m_tdata),
        .m_tready (m_tready)
    );

    for (genvar k = 0; k < NUM_PE; k++) begin : g_route
        assign pe_route[k] = DESTW'(route_tab[k]);
    end

    always #2 CLK = ~CLK;

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, what, got, exp);
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] rnd;
        rnd = $random(seed);
        return int'(rnd % 32'(n));
    endfunction

    // one element: op on value, hops plus one, op and imm kept
    function automatic logic [31:0] element_result(input logic [31:0] w);
        logic [15:0] imm16;
        logic [15:0] nv;
        logic [31:0] prod;
        imm16 = {6'd0, w[25:16]};
        prod  = {16'd0, w[15:0]} * {16'd0, imm16};
        case (w[31:30])
            pe_word_pkg::OP_ADD: nv = w[15:0] + imm16;
            pe_word_pkg::OP_XOR: nv = w[15:0] ^ imm16;
            pe_word_pkg::OP_MUL: nv = prod[15:0];
            default:             nv = w[15:0];
        endcase
        return {w[31:30], w[29:26] + 4'd1, w[25:16], nv};
    endfunction

    // follow the routes until the word reaches the host
    function automatic logic [31:0] expected_result(input logic [31:0] w, input int dest);
        logic [31:0] r;
        int          d;
        int          steps;
        r     = w;
        d     = dest;
        steps = 0;
        while (d < NUM_PE && steps <= NUM_PE) begin
            r = element_result(r);
            d = route_tab[d];
            steps++;
        end
        return r;
    endfunction

    task automatic send_words();
        int wait_cnt;
        while (tx_word_q.size() > 0) begin
            @(negedge CLK);
            s_tvalid = 1'b1;
            s_tdata  = tx_word_q[0];
            s_tdest  = DESTW'(tx_dest_q[0]);
            wait_cnt = 0;
            #1;
            while (!s_tready && wait_cnt < TIMEOUT) begin
                stall_cnt++;
                @(negedge CLK);
                #1;
                wait_cnt++;
            end
            if (!s_tready) begin
                err_cnt++;
                $display("timeout at %0t: host input never became ready", $time);
                tx_word_q.delete();
                tx_dest_q.delete();
            end else begin
                // transfer on this edge
                @(posedge CLK);
                tx_word_q.delete(0);
                tx_dest_q.delete(0);
            end
        end
        @(negedge CLK);
        s_tvalid = 1'b0;
    endtask

    // unordered match, each hit removed from the expected set
    task automatic match_result(input logic [31:0] got);
        int hit;
        hit = -1;
        foreach (exp_q[i]) begin
            if (hit < 0 && exp_q[i] == got) begin
                hit = i;
            end
        end
        check_eq(32'(hit >= 0), 32'd1, $sformatf("result %h not among expected words", got));
        if (hit >= 0) begin
            exp_q.delete(hit);
        end
    endtask

    task automatic collect_results(input int n, input bit random_ready);
        int          got_cnt;
        int          idle;
        logic [31:0] rnd;
        got_cnt = 0;
        idle    = 0;
        while (got_cnt < n && idle < TIMEOUT) begin
            @(negedge CLK);
            rnd      = $random(seed);
            m_tready = random_ready ? rnd[0] : 1'b1;
            #1;
            if (m_tvalid && m_tready) begin
                match_result(m_tdata);
                got_cnt++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got_cnt < n) begin
            err_cnt++;
            $display("timeout at %0t: only %0d of %0d results arrived", $time, got_cnt, n);
        end
        // nothing may follow the last expected word
        @(negedge CLK);
        m_tready = 1'b1;
        repeat (20) begin
            #1;
            check_eq(32'(m_tvalid), 32'd0, "extra word on host output");
            @(negedge CLK);
        end
        check_eq(32'(exp_q.size()), 32'd0, "expected words never delivered");
    endtask

    task automatic run_batch(input bit random_ready);
        int n;
        n = tx_word_q.size();
        exp_q.delete();
        foreach (tx_word_q[i]) begin
            exp_q.push_back(expected_result(tx_word_q[i], tx_dest_q[i]));
        end
        fork
            send_words();
            collect_results(n, random_ready);
        join
    endtask

    task automatic test_reset_idle();
        @(negedge CLK);
        repeat (20) begin
            #1;
            check_eq(32'(m_tvalid), 32'd0, "m_tvalid raised with no input");
            @(negedge CLK);
        end
    endtask

    // every op through every element, straight back to the host
    task automatic test_single_hop();
        logic [31:0] rnd;
        foreach (route_tab[k]) begin
            route_tab[k] = NUM_PE;
        end
        for (int k = 0; k < NUM_PE; k++) begin
            for (int op = 0; op < 4; op++) begin
                rnd = $random(seed);
                tx_word_q.push_back({2'(op), 4'd0, rnd[25:16], rnd[15:0]});
                tx_dest_q.push_back(k);
            end
        end
        run_batch(1'b0);
    endtask

    // element k feeds k+1, the last one the host
    task automatic test_chain();
        logic [31:0] rnd;
        foreach (route_tab[k]) begin
            route_tab[k] = k + 1;
        end
        for (int op = 0; op < 4; op++) begin
            rnd = $random(seed);
            tx_word_q.push_back({2'(op), 4'd0, rnd[25:16], rnd[15:0]});
            tx_dest_q.push_back(0);
        end
        run_batch(1'b0);
    endtask

    // host to host, no element touches it
    task automatic test_host_loop();
        logic [31:0] rnd;
        repeat (4) begin
            rnd = $random(seed);
            tx_word_q.push_back({rnd[31:30], 4'd0, rnd[25:16], rnd[15:0]});
            tx_dest_q.push_back(NUM_PE);
        end
        run_batch(1'b0);
    endtask

    task automatic test_backpressure();
        logic [31:0] rnd;
        // forward-only routes, no loops
        for (int k = 0; k < NUM_PE; k++) begin
            route_tab[k] = k + 1 + rand_below(NUM_PE - k);
        end
        repeat (30) begin
            rnd = $random(seed);
            tx_word_q.push_back({rnd[31:30], 4'd0, rnd[25:16], rnd[15:0]});
            tx_dest_q.push_back(rand_below(NUM_PE));
        end
        stall_cnt = 0;
        run_batch(1'b1);
        // a backed-up cluster must push back on the host
        check_eq(32'(stall_cnt > 0), 32'd1, "s_tready never fell under back-pressure");
    endtask

    initial begin
        seed      = 32'h3cfc;
        err_cnt   = 0;
        check_cnt = 0;
        stall_cnt = 0;
        CLK       = 1'b0;
        rst_n     = 1'b0;
        s_tvalid  = 1'b0;
        s_tdata   = '0;
        s_tdest   = '0;
        m_tready  = 1'b0;
        foreach (route_tab[k]) begin
            route_tab[k] = NUM_PE;
        end
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        test_reset_idle();
        test_single_hop();
        test_chain();
        test_host_loop();
        test_backpressure();
        $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/pe_cluster_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_cluster_properties #(
    parameter int NUM_PE = 4,
    parameter int DESTW  = 3
) (
    input wire logic                               CLK,
    input wire logic                               rst_n,
    input wire logic                               s_tvalid,
    input wire logic [DESTW-1:0]                   s_tdest,
    input wire logic                               m_tvalid,
    input wire logic [cluster_cfg_pkg::DATAW-1:0]  m_tdata,
    input wire logic                               m_tready
);

    // host may address an element or itself, nothing above
    a_dest_legal: assert property (@(posedge CLK) disable iff (!rst_n)
        s_tvalid |-> (s_tdest <= DESTW'(NUM_PE)))
        else $error("host tdest beyond the host port index");

    // stalled output keeps its word
    a_out_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata)))
        else $error("host output changed before m_tready");

    a_reset_quiet: assert property (@(posedge CLK) !rst_n |-> !m_tvalid)
        else $error("m_tvalid high during reset");

endmodule

bind pe_cluster_top pe_cluster_properties #(
    .NUM_PE (NUM_PE),
    .DESTW  (DESTW)
) i_props (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .s_tvalid (s_tvalid),
    .s_tdest  (s_tdest),
    .m_tvalid (m_tvalid),
    .m_tdata  (m_tdata),
    .m_tready (m_tready)
);

`default_nettype wire

/* hw/pe_cluster_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_cluster_top #(
    parameter int NUM_PE = cluster_cfg_pkg::DEF_NUM_PE,
    parameter int DESTW  = cluster_cfg_pkg::DEF_DESTW
) (
    input  wire logic                                   CLK,
    input  wire logic                                   rst_n,

    // host in, switch port NUM_PE
    input  wire logic                                   s_tvalid,
    input  wire logic [cluster_cfg_pkg::DATAW-1:0]      s_tdata,
    input  wire logic [DESTW-1:0]                       s_tdest,
    output logic                                        s_tready,

    // result destination of each element
    input  wire logic [NUM_PE-1:0][DESTW-1:0]           pe_route,

    // host out, switch port NUM_PE
    output logic                                        m_tvalid,
    output logic      [cluster_cfg_pkg::DATAW-1:0]      m_tdata,
    input  wire logic                                   m_tready
);

    logic [NUM_PE:0]                              sw_in_tvalid;
    logic [NUM_PE:0][cluster_cfg_pkg::DATAW-1:0]  sw_in_tdata;
    logic [NUM_PE:0][DESTW-1:0]                   sw_in_tdest;
    logic [NUM_PE:0]                              sw_in_tready;
    logic [NUM_PE:0]                              sw_out_tvalid;
    logic [NUM_PE:0][cluster_cfg_pkg::DATAW-1:0]  sw_out_tdata;
    logic [NUM_PE:0]                              sw_out_tready;

    // host takes the last port on both sides
    assign sw_in_tvalid[NUM_PE]  = s_tvalid;
    assign sw_in_tdata[NUM_PE]   = s_tdata;
    assign sw_in_tdest[NUM_PE]   = s_tdest;
    assign s_tready              = sw_in_tready[NUM_PE];
    assign m_tvalid              = sw_out_tvalid[NUM_PE];
    assign m_tdata               = sw_out_tdata[NUM_PE];
    assign sw_out_tready[NUM_PE] = m_tready;

    stream_switch #(
        .NUM_PE (NUM_PE),
        .DESTW  (DESTW)
    ) i_switch (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .in_tvalid  (sw_in_tvalid),
        .in_tdata   (sw_in_tdata),
        .in_tdest   (sw_in_tdest),
        .in_tready  (sw_in_tready),
        .out_tvalid (sw_out_tvalid),
        .out_tdata  (sw_out_tdata),
        .out_tready (sw_out_tready)
    );

    // element k sits between switch output k and input k
    for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
        assign sw_in_tdest[k] = pe_route[k];

        pe_wrapper i_pe (
            .CLK        (CLK),
            .rst_n      (rst_n),
            .in_tvalid  (sw_out_tvalid[k]),
            .in_tdata   (sw_out_tdata[k]),
            .in_tready  (sw_out_tready[k]),
            .out_tvalid (sw_in_tvalid[k]),
            .out_tdata  (sw_in_tdata[k]),
            .out_tready (sw_in_tready[k])
        );
    end

endmodule

`default_nettype wire

/* hw/pe_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_wrapper (
    input  wire logic                       CLK,
    input  wire logic                       rst_n,

    // from the switch
    input  wire logic                       in_tvalid,
    input  wire pe_word_pkg::stream_word_u  in_tdata,
    output logic                            in_tready,

    // back into the switch
    output logic                            out_tvalid,
    output pe_word_pkg::stream_word_u       out_tdata,
    input  wire logic                       out_tready
);

    logic                 load;
    logic                 start;
    logic                 finish;
    logic                 done;
    // alu op straight into the timer
    pe_word_pkg::pe_op_e  op;

    pe_sequencer i_seq (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .in_tvalid  (in_tvalid),
        .done       (done),
        .out_tready (out_tready),
        .in_tready  (in_tready),
        .load       (load),
        .start      (start),
        .finish     (finish),
        .out_tvalid (out_tvalid)
    );

    pe_latency_timer i_timer (
        .CLK   (CLK),
        .rst_n (rst_n),
        .start (start),
        .op    (op),
        .done  (done)
    );

    pe_alu i_alu (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .load      (load),
        .in_tdata  (in_tdata),
        .finish    (finish),
        .op        (op),
        .out_tdata (out_tdata)
    );

endmodule

`default_nettype wire

/* hw/pe_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_sequencer (
    input  wire logic  CLK,
    input  wire logic  rst_n,
    input  wire logic  in_tvalid,
    input  wire logic  done,
    input  wire logic  out_tready,
    output logic       in_tready,
    output logic       load,
    output logic       start,
    output logic       finish,
    output logic       out_tvalid
);

    // state encodings
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_HOLD = 2'd2;

    logic [1:0] state;

    // accept only while empty
    assign in_tready  = (state == ST_IDLE);
    assign load       = in_tready && in_tvalid;
    // timer starts with the capture
    assign start      = load;
    // result written back as the timer expires
    assign finish     = (state == ST_BUSY) && done;
    assign out_tvalid = (state == ST_HOLD);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (finish) begin
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // idle again after the output transfer
                    if (out_tready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/pe_latency_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_latency_timer (
    input  wire logic                 CLK,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire pe_word_pkg::pe_op_e  op,
    output logic                      done
);

    // enough for the longest op
    localparam int CNT_W = 3;

    logic [CNT_W-1:0] cnt;
    logic             running;

    // fires on the last cycle of the op
    assign done = running && (cnt == '0);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (start) begin
            // minus one, done itself is the last cycle
            cnt     <= CNT_W'(pe_word_pkg::OP_LATENCY[op] - 1);
            running <= 1'b1;
        end else if (done) begin
            running <= 1'b0;
        end else if (running) begin
            cnt <= cnt - CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

/* hw/pe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_alu (
    input  wire logic                       CLK,
    input  wire logic                       rst_n,
    input  wire logic                       load,
    input  wire pe_word_pkg::stream_word_u  in_tdata,
    input  wire logic                       finish,
    output pe_word_pkg::pe_op_e             op,
    output pe_word_pkg::stream_word_u       out_tdata
);

    // imm widened to the value width
    logic [15:0] imm_ext;
    // new value for the held word
    logic [15:0] result;

    // incoming op on the capture cycle so the timer sees it at once
    assign op = load ? in_tdata.cmd.op : out_tdata.cmd.op;

    assign imm_ext = {6'd0, out_tdata.cmd.imm};

    always_comb begin
        case (out_tdata.cmd.op)
            pe_word_pkg::OP_ADD:  result = out_tdata.cmd.value + imm_ext;
            pe_word_pkg::OP_XOR:  result = out_tdata.cmd.value ^ imm_ext;
            // low half of the product only
            pe_word_pkg::OP_MUL:  result = out_tdata.cmd.value * imm_ext;
            default:              result = out_tdata.cmd.value;
        endcase
    end

    // held word, result written back in place
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            out_tdata <= '0;
        end else if (load) begin
            out_tdata <= in_tdata;
        end else if (finish) begin
            // op and imm are kept
            out_tdata.cmd.value <= result;
            out_tdata.cmd.hops  <= out_tdata.cmd.hops + 4'd1;
        end
    end

endmodule

`default_nettype wire

/* hw/stream_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_switch #(
    parameter int NUM_PE = 4,
    parameter int DESTW  = 3
) (
    input  wire logic                                             CLK,
    input  wire logic                                             rst_n,

    // sources, index NUM_PE is the host
    input  wire logic [NUM_PE:0]                                  in_tvalid,
    input  wire logic [NUM_PE:0][cluster_cfg_pkg::DATAW-1:0]      in_tdata,
    input  wire logic [NUM_PE:0][DESTW-1:0]                       in_tdest,
    output logic      [NUM_PE:0]                                  in_tready,

    // sinks, one register each
    output logic      [NUM_PE:0]                                  out_tvalid,
    output logic      [NUM_PE:0][cluster_cfg_pkg::DATAW-1:0]      out_tdata,
    input  wire logic [NUM_PE:0]                                  out_tready
);

    localparam int NP   = NUM_PE + 1;
    localparam int IDXW = (NP > 1) ? $clog2(NP) : 1;

    // request matrix, [output][input]
    logic [NP-1:0][NP-1:0]   req;
    // one-hot grant per output
    logic [NP-1:0][NP-1:0]   gnt;
    logic [NP-1:0][IDXW-1:0] gnt_idx;
    logic [NP-1:0]           gnt_any;
    // round-robin start point per output
    logic [NP-1:0][IDXW-1:0] rr_ptr;
    // register empty or draining this cycle
    logic [NP-1:0]           can_load;

    assign can_load = ~out_tvalid | out_tready;

    // decode destinations into per-output requests
    always_comb begin
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                req[o][i] = in_tvalid[i] && (in_tdest[i] == DESTW'(o));
            end
        end
    end

    // arbiter: first requester at or after the pointer wins
    always_comb begin
        int idx;
        for (int o = 0; o < NP; o++) begin
            gnt[o]     = '0;
            gnt_idx[o] = '0;
            gnt_any[o] = 1'b0;
            for (int off = 0; off < NP; off++) begin
                idx = int'(rr_ptr[o]) + off;
                // wrap around the port count
                if (idx >= NP) begin
                    idx = idx - NP;
                end
                if (!gnt_any[o] && req[o][idx]) begin
                    gnt_any[o] = 1'b1;
                    gnt_idx[o] = IDXW'(idx);
                end
            end
            gnt[o][gnt_idx[o]] = gnt_any[o];
        end
    end

    // ready only from the output that granted this input
    always_comb begin
        for (int i = 0; i < NP; i++) begin
            in_tready[i] = 1'b0;
            for (int o = 0; o < NP; o++) begin
                in_tready[i] = in_tready[i] | (gnt[o][i] & can_load[o]);
            end
        end
    end

    // output valids and pointers
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            out_tvalid <= '0;
            rr_ptr     <= '0;
        end else begin
            for (int o = 0; o < NP; o++) begin
                if (can_load[o]) begin
                    // empties when nothing is granted
                    out_tvalid[o] <= gnt_any[o];
                    if (gnt_any[o]) begin
                        // winner goes to the back
                        if (int'(gnt_idx[o]) == NP - 1) begin
                            rr_ptr[o] <= '0;
                        end else begin
                            rr_ptr[o] <= gnt_idx[o] + IDXW'(1);
                        end
                    end
                end
            end
        end
    end

    // payload, loaded with the granted word
    always_ff @(posedge CLK) begin
        for (int o = 0; o < NP; o++) begin
            if (can_load[o] && gnt_any[o]) begin
                out_tdata[o] <= in_tdata[gnt_idx[o]];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/pe_word_pkg.sv */
`default_nettype none

// how a processing element reads a stream word
package pe_word_pkg;

    // operation codes, top two bits of the word
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_XOR  = 2'd1,
        OP_MUL  = 2'd2,
        OP_PASS = 2'd3
    } pe_op_e;

    // field view, msb first
    typedef struct packed {
        pe_op_e      op;
        logic [3:0]  hops;
        logic [9:0]  imm;
        logic [15:0] value;
    } pe_cmd_t;

    // switch moves raw, element decodes cmd
    typedef union packed {
        logic [cluster_cfg_pkg::DATAW-1:0] raw;
        pe_cmd_t                           cmd;
    } stream_word_u;

    // cycles from input transfer to result, indexed by op
    localparam int unsigned OP_LATENCY [4] = '{1, 1, 4, 1};

endpackage

`default_nettype wire

/* hw/cluster_cfg_pkg.sv */
`default_nettype none

// sizes shared by the whole cluster
package cluster_cfg_pkg;

    // word width on every stream link
    // pe_word_pkg sizes its union from this, so it stays at 32
    localparam int DATAW = 32;

    // default element count
    // the top level can override it
    localparam int DEF_NUM_PE = 4;

    // default tdest width
    // must hold NUM_PE, the host port index
    localparam int DEF_DESTW = 3;

endpackage

`default_nettype wire
